/* common/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and address width
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_REGS 32

// Instruction memory depth in words
`define MIPS_IMEM_DEPTH 64

// Data memory depth in words
`define MIPS_DMEM_DEPTH 64

// Idle word, decodes to a bubble
`define MIPS_NOP 32'h0000_0000

`endif

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// Major opcodes in bits 31..26
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opAddiu = 6'h09,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// Function field of SPECIAL
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// Zero is add so a bubble is harmless
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// One instruction word, two field layouts
	typedef union packed {
		struct packed {
			opcodeT opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			functT funct;
		} rType;
		struct packed {
			opcodeT opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

	// WB fields, then MEM fields, then EXE fields
	// All zero means bubble
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;
		logic regDstRd;
		aluOpT aluOp;
	} ctrlWord;

endpackage

`default_nettype wire

/* fetch/InstructionFetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module InstructionFetch (
	input wire logic clk,
	input wire logic rst,
	input wire logic pcWrite,
	input wire logic ifIdWrite,
	input wire logic imemWe,
	input wire logic [`MIPS_XLEN-1:0] imemAddr,
	input wire logic [`MIPS_XLEN-1:0] imemData,
	output mips_pkg::instrWord ifInstr,
	output logic [`MIPS_XLEN-1:0] ifPc
);

	localparam int ImemAw = $clog2(`MIPS_IMEM_DEPTH);

	logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH];
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] fetchWord;
	logic pcInRange;

	// Load port takes a word index
	always_ff @(posedge clk)
	begin
		if (imemWe && (imemAddr < `MIPS_IMEM_DEPTH))
			imem[imemAddr[ImemAw-1:0]] <= imemData;
	end

	// Byte PC, word lookup
	assign pcInRange = (pc[`MIPS_XLEN-1:2] < `MIPS_IMEM_DEPTH);
	// Past the end reads as NOP
	assign fetchWord = pcInRange ? imem[pc[ImemAw+1:2]] : `MIPS_NOP;

	// Program counter
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (pcWrite)
			pc <= pc + `MIPS_XLEN'd4;
	end

	////////////////////////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ifInstr <= `MIPS_NOP;
			ifPc <= '0;
		end
		else if (ifIdWrite)
		begin
			ifInstr <= fetchWord;
			ifPc <= pc;
		end
	end

endmodule

`default_nettype wire

/* decode/HazardDetectionUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module HazardDetectionUnit (
	input wire logic exMemRead,
	input wire logic [4:0] exDest,
	input wire logic [4:0] rs,
	input wire logic [4:0] rt,
	input wire logic debugOn,
	output logic pcWrite,
	output logic ifIdWrite,
	output logic bubble
);

	logic loadUse;

	// Load in EX feeds the instruction in IF/ID
	assign loadUse = exMemRead && (exDest != 5'd0) && ((exDest == rs) || (exDest == rt));

	// Debug halt freezes fetch and drains the back end
	assign bubble = loadUse || debugOn;

	// Fetch side holds while a bubble goes in
	assign pcWrite = !bubble;
	assign ifIdWrite = !bubble;

endmodule

`default_nettype wire

/* decode/ControlBlock.sv */
`timescale 1ns/1ps
`default_nettype none

module ControlBlock (
	input wire mips_pkg::instrWord instr,
	output mips_pkg::ctrlWord ctrl
);

	import mips_pkg::*;

	always_comb
	begin
		// Anything not listed stays a bubble
		ctrl = '0;
		case (instr.iType.opcode)
			opSpecial:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (instr.rType.funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt;
					// Covers the all zero NOP too
					default: ctrl = '0;
				endcase
			end
			opAddiu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opLw:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			// Address is base plus offset
			opSw:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

/* decode/FileRegister.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module FileRegister (
	input wire logic clk,
	input wire logic rst,
	input wire logic write,
	input wire logic [4:0] writeReg,
	input wire logic [`MIPS_XLEN-1:0] writeData,
	input wire logic [4:0] readReg1,
	input wire logic [4:0] readReg2,
	input wire logic [4:0] debugReg,
	output logic [`MIPS_XLEN-1:0] readData1,
	output logic [`MIPS_XLEN-1:0] readData2,
	output logic [`MIPS_XLEN-1:0] debugData
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_REGS];

	// Register 0 is never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `MIPS_REGS; i++)
				regs[i] <= '0;
		end
		else if (write && (writeReg != 5'd0))
			regs[writeReg] <= writeData;
	end

	// Zero first, then the pending write, then storage
	function automatic logic [`MIPS_XLEN-1:0] readPort(input logic [4:0] sel);
		logic [`MIPS_XLEN-1:0] value;
		if (sel == 5'd0)
			value = '0;
		else if (write && (writeReg == sel))
			value = writeData;
		else
			value = regs[sel];
		return value;
	endfunction

	// Same rule on every read port
	always_comb
	begin
		readData1 = readPort(readReg1);
		readData2 = readPort(readReg2);
		debugData = readPort(debugReg);
	end

endmodule

`default_nettype wire

/* decode/InstructionDecode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module InstructionDecode (
	input wire logic clk,
	input wire logic rst,
	input wire mips_pkg::instrWord ifInstr,
	input wire logic [`MIPS_XLEN-1:0] ifPc,
	input wire logic exMemRead,
	input wire logic [4:0] exDest,
	input wire logic fwdValid,
	input wire logic [4:0] fwdReg,
	input wire logic [`MIPS_XLEN-1:0] fwdData,
	input wire logic wbWrite,
	input wire logic [4:0] wbReg,
	input wire logic [`MIPS_XLEN-1:0] wbData,
	input wire logic debugOn,
	input wire logic [4:0] debugReg,
	output logic pcWrite,
	output logic ifIdWrite,
	output mips_pkg::ctrlWord exCtrl,
	output logic [`MIPS_XLEN-1:0] exRegA,
	output logic [`MIPS_XLEN-1:0] exRegB,
	output logic [`MIPS_XLEN-1:0] exImm,
	output logic [4:0] exRt,
	output logic [4:0] exRd,
	output logic [`MIPS_XLEN-1:0] exPc,
	output logic [`MIPS_XLEN-1:0] debugData
);

	import mips_pkg::*;

	ctrlWord idCtrl;
	logic bubble;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [`MIPS_XLEN-1:0] fileA;
	logic [`MIPS_XLEN-1:0] fileB;
	logic [`MIPS_XLEN-1:0] opA;
	logic [`MIPS_XLEN-1:0] opB;
	logic [`MIPS_XLEN-1:0] immExt;

	assign rs = ifInstr.rType.rs;
	assign rt = ifInstr.rType.rt;

	// Stall and bubble request
	HazardDetectionUnit u_HazardDetectionUnit (
		.exMemRead(exMemRead),
		.exDest(exDest),
		.rs(rs),
		.rt(rt),
		.debugOn(debugOn),
		.pcWrite(pcWrite),
		.ifIdWrite(ifIdWrite),
		.bubble(bubble)
	);

	ControlBlock u_ControlBlock (
		.instr(ifInstr),
		.ctrl(idCtrl)
	);

	// WB writes go straight through to the read ports
	FileRegister u_FileRegister (
		.clk(clk),
		.rst(rst),
		.write(wbWrite),
		.writeReg(wbReg),
		.writeData(wbData),
		.readReg1(rs),
		.readReg2(rt),
		.debugReg(debugReg),
		.readData1(fileA),
		.readData2(fileB),
		.debugData(debugData)
	);

	////////////////////////////////////////////////////////////
	// EX forward over the register file
	////////////////////////////////////////////////////////////
	function automatic logic [`MIPS_XLEN-1:0] pickOperand(
		input logic [4:0] sel,
		input logic [`MIPS_XLEN-1:0] fileValue
	);
		logic hit;
		// Register 0 never forwards
		hit = fwdValid && (fwdReg != 5'd0) && (fwdReg == sel);
		return hit ? fwdData : fileValue;
	endfunction

	always_comb
	begin
		opA = pickOperand(rs, fileA);
		opB = pickOperand(rt, fileB);
	end

	// Sign extended 16 bit immediate
	assign immExt = {{(`MIPS_XLEN-16){ifInstr.iType.imm[15]}}, ifInstr.iType.imm};

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			exCtrl <= '0;
		else if (bubble)
			exCtrl <= '0;
		else
			exCtrl <= idCtrl;
	end

	// Operands and fields
	always_ff @(posedge clk)
	begin
		exRegA <= opA;
		exRegB <= opB;
		exImm <= immExt;
		exRt <= rt;
		exRd <= ifInstr.rType.rd;
		exPc <= ifPc;
	end

endmodule

`default_nettype wire

/* hdl/ExecuteStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module ExecuteStage (
	input wire logic clk,
	input wire logic rst,
	input wire mips_pkg::ctrlWord exCtrl,
	input wire logic [`MIPS_XLEN-1:0] exRegA,
	input wire logic [`MIPS_XLEN-1:0] exRegB,
	input wire logic [`MIPS_XLEN-1:0] exImm,
	input wire logic [4:0] exRt,
	input wire logic [4:0] exRd,
	output logic exMemRead,
	output logic [4:0] exDest,
	output logic fwdValid,
	output logic [4:0] fwdReg,
	output logic [`MIPS_XLEN-1:0] fwdData,
	output logic wbWrite,
	output logic [4:0] wbReg,
	output logic [`MIPS_XLEN-1:0] wbData,
	output logic retireValid,
	output logic [4:0] retireReg,
	output logic [`MIPS_XLEN-1:0] retireData
);

	import mips_pkg::*;

	localparam int DmemAw = $clog2(`MIPS_DMEM_DEPTH);

	logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_DEPTH];
	logic [`MIPS_XLEN-1:0] aluB;
	logic [`MIPS_XLEN-1:0] aluResult;
	logic lessThan;
	logic [DmemAw-1:0] memIdx;
	logic wbValid;
	logic [4:0] wbDest;
	logic [`MIPS_XLEN-1:0] wbValue;

	// Operand and destination select
	assign aluB = exCtrl.aluSrcImm ? exImm : exRegB;
	assign exDest = exCtrl.regDstRd ? exRd : exRt;
	assign exMemRead = exCtrl.memRead;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	assign lessThan = ($signed(exRegA) < $signed(aluB));

	always_comb
	begin
		case (exCtrl.aluOp)
			aluAdd: aluResult = exRegA + aluB;
			aluSub: aluResult = exRegA - aluB;
			aluAnd: aluResult = exRegA & aluB;
			aluOr: aluResult = exRegA | aluB;
			aluSlt: aluResult = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
			default: aluResult = '0;
		endcase
	end

	// Loads are not ready until WB
	assign fwdValid = exCtrl.regWrite && !exCtrl.memRead;
	assign fwdReg = exDest;
	assign fwdData = aluResult;

	////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////
	// Word aligned, upper address bits ignored
	assign memIdx = aluResult[DmemAw+1:2];

	always_ff @(posedge clk)
	begin
		if (exCtrl.memWrite)
			dmem[memIdx] <= exRegB;
	end

	// Writeback register
	always_ff @(posedge clk)
	begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= exCtrl.regWrite;
	end

	// Synchronous read lands here
	always_ff @(posedge clk)
	begin
		wbDest <= exDest;
		wbValue <= exCtrl.memToReg ? dmem[memIdx] : aluResult;
	end

	// Same contents feed the register file and the retire port
	assign wbWrite = wbValid;
	assign wbReg = wbDest;
	assign wbData = wbValue;
	assign retireValid = wbValid;
	assign retireReg = wbDest;
	assign retireData = wbValue;

endmodule

`default_nettype wire

/* hdl/MipsCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module MipsCore (
	input wire logic clk,
	input wire logic rst,
	input wire logic imemWe,
	input wire logic [`MIPS_XLEN-1:0] imemAddr,
	input wire logic [`MIPS_XLEN-1:0] imemData,
	input wire logic debugOn,
	input wire logic [4:0] debugReg,
	output logic [`MIPS_XLEN-1:0] debugData,
	output logic retireValid,
	output logic [4:0] retireReg,
	output logic [`MIPS_XLEN-1:0] retireData
);

	import mips_pkg::*;

	// Fetch and decode
	instrWord ifInstr;
	logic [`MIPS_XLEN-1:0] ifPc;
	logic pcWrite;
	logic ifIdWrite;

	// ID/EX
	ctrlWord exCtrl;
	logic [`MIPS_XLEN-1:0] exRegA;
	logic [`MIPS_XLEN-1:0] exRegB;
	logic [`MIPS_XLEN-1:0] exImm;
	logic [4:0] exRt;
	logic [4:0] exRd;

	// Feedback from execute
	logic exMemRead;
	logic [4:0] exDest;
	logic fwdValid;
	logic [4:0] fwdReg;
	logic [`MIPS_XLEN-1:0] fwdData;
	logic wbWrite;
	logic [4:0] wbReg;
	logic [`MIPS_XLEN-1:0] wbData;

	InstructionFetch u_InstructionFetch (
		.clk(clk),
		.rst(rst),
		.pcWrite(pcWrite),
		.ifIdWrite(ifIdWrite),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifInstr(ifInstr),
		.ifPc(ifPc)
	);

	// PC rides along in ID/EX but execute has no use for it
	InstructionDecode u_InstructionDecode (
		.clk(clk),
		.rst(rst),
		.ifInstr(ifInstr),
		.ifPc(ifPc),
		.exMemRead(exMemRead),
		.exDest(exDest),
		.fwdValid(fwdValid),
		.fwdReg(fwdReg),
		.fwdData(fwdData),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.debugOn(debugOn),
		.debugReg(debugReg),
		.pcWrite(pcWrite),
		.ifIdWrite(ifIdWrite),
		.exCtrl(exCtrl),
		.exRegA(exRegA),
		.exRegB(exRegB),
		.exImm(exImm),
		.exRt(exRt),
		.exRd(exRd),
		.exPc(),
		.debugData(debugData)
	);

	ExecuteStage u_ExecuteStage (
		.clk(clk),
		.rst(rst),
		.exCtrl(exCtrl),
		.exRegA(exRegA),
		.exRegB(exRegB),
		.exImm(exImm),
		.exRt(exRt),
		.exRd(exRd),
		.exMemRead(exMemRead),
		.exDest(exDest),
		.fwdValid(fwdValid),
		.fwdReg(fwdReg),
		.fwdData(fwdData),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData)
	);

endmodule

`default_nettype wire

/* test/MipsCore_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module MipsCore_asserts (
	input wire logic clk,
	input wire logic rst,
	input wire logic debugOn,
	input wire logic pcWrite,
	input wire logic ifIdWrite,
	input wire mips_pkg::ctrlWord exCtrl
);

	// Number of failed assertions
	int failCount = 0;

	// Load use holds fetch for one cycle only
	stallOnce: assert property (@(posedge clk) disable iff (rst)
		(!pcWrite && !debugOn) |=> (pcWrite || debugOn))
	else
	begin
		failCount++;
		$error("stall held two cycles without debug halt");
	end

	// Both fetch enables come from one compare
	enablesMatch: assert property (@(posedge clk) disable iff (rst)
		pcWrite == ifIdWrite)
	else
	begin
		failCount++;
		$error("pcWrite and ifIdWrite differ");
	end

	// A stall puts a bubble into ID/EX
	bubbleAfterStall: assert property (@(posedge clk) disable iff (rst)
		!pcWrite |=> (exCtrl == '0))
	else
	begin
		failCount++;
		$error("ID/EX control word not a bubble after stall");
	end

endmodule

bind InstructionDecode MipsCore_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.debugOn(debugOn),
	.pcWrite(pcWrite),
	.ifIdWrite(ifIdWrite),
	.exCtrl(exCtrl)
);

`default_nettype wire

/* test/MipsCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module MipsCore_tb;

	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 3;
	localparam int ProgLen = 20;
	// PC edge, IF/ID, ID/EX, then WB
	localparam int RetireLatency = 3;
	localparam int DebugCycles = 2 * `MIPS_REGS;
	// Load, reset, program, drain and debug reads plus margin
	localparam int RunCycles = 2 * ProgLen + ResetCycles + RetireLatency + DebugCycles + 30;

	// MIPS32 encodings
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpAddiu = 6'h09;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpSw = 6'h2b;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnSlt = 6'h2a;

	logic clk;
	logic rst;
	logic imemWe;
	logic [`MIPS_XLEN-1:0] imemAddr;
	logic [`MIPS_XLEN-1:0] imemData;
	logic debugOn;
	logic [4:0] debugReg;
	logic [`MIPS_XLEN-1:0] debugData;
	logic retireValid;
	logic [4:0] retireReg;
	logic [`MIPS_XLEN-1:0] retireData;

	// Program table with one row per instruction word
	logic [`MIPS_XLEN-1:0] progInstr [ProgLen];
	logic [4:0] progDest [ProgLen];
	int rowCount;
	logic [31:0] seed;

	// Reference model state
	logic [`MIPS_XLEN-1:0] modelRegs [`MIPS_REGS];
	logic [`MIPS_XLEN-1:0] modelMem [`MIPS_DMEM_DEPTH];

	// Expected retire stream
	int expCycle [$];
	logic [4:0] expReg [$];
	logic [`MIPS_XLEN-1:0] expData [$];

	MipsCore u_MipsCore (
		.clk(clk),
		.rst(rst),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.debugOn(debugOn),
		.debugReg(debugReg),
		.debugData(debugData),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] encodeR(
		input logic [5:0] funct,
		input logic [4:0] rd,
		input logic [4:0] rs,
		input logic [4:0] rt
	);
		return {OpSpecial, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encodeI(
		input logic [5:0] op,
		input logic [4:0] rt,
		input logic [4:0] rs,
		input logic [15:0] imm
	);
		return {op, rs, rt, imm};
	endfunction

	task automatic drawImmediate(output logic [15:0] imm);
		seed = xorshift32(seed);
		imm = seed[15:0];
	endtask

	task automatic addRow(input logic [31:0] instr, input logic [4:0] dest);
		progInstr[rowCount] = instr;
		progDest[rowCount] = dest;
		rowCount++;
	endtask

	task automatic checkValue(
		input string name,
		input logic [31:0] actual,
		input logic [31:0] expected
	);
		if (actual !== expected)
		begin
			$display("** Error: %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Program table
	////////////////////////////////////////////////////////////
	task automatic buildProgram();
		logic [15:0] imm;
		rowCount = 0;
		drawImmediate(imm);
		addRow(encodeI(OpAddiu, 5'd1, 5'd0, imm), 5'd1);
		drawImmediate(imm);
		addRow(encodeI(OpAddiu, 5'd2, 5'd0, imm), 5'd2);
		// r2 by EX forward and r1 by write-through
		addRow(encodeR(FnAddu, 5'd3, 5'd1, 5'd2), 5'd3);
		addRow(encodeR(FnSubu, 5'd4, 5'd3, 5'd1), 5'd4);
		addRow(encodeR(FnAnd, 5'd5, 5'd3, 5'd2), 5'd5);
		addRow(encodeR(FnOr, 5'd6, 5'd4, 5'd5), 5'd6);
		// Signed compare both ways
		addRow(encodeR(FnSlt, 5'd7, 5'd1, 5'd2), 5'd7);
		addRow(encodeR(FnSlt, 5'd8, 5'd2, 5'd1), 5'd8);
		// Store then load back the same word
		addRow(encodeI(OpSw, 5'd3, 5'd0, 16'h0010), 5'd0);
		addRow(encodeI(OpLw, 5'd9, 5'd0, 16'h0010), 5'd9);
		// Load use costs one bubble
		addRow(encodeR(FnAddu, 5'd10, 5'd9, 5'd1), 5'd10);
		drawImmediate(imm);
		addRow(encodeI(OpAddiu, 5'd11, 5'd0, imm), 5'd11);
		addRow(encodeI(OpLw, 5'd12, 5'd0, 16'h0010), 5'd12);
		// Independent of the load
		drawImmediate(imm);
		addRow(encodeI(OpAddiu, 5'd13, 5'd0, imm), 5'd13);
		// r0 target retires but keeps reading zero
		drawImmediate(imm);
		addRow(encodeI(OpAddiu, 5'd0, 5'd1, imm), 5'd0);
		addRow(encodeR(FnAddu, 5'd14, 5'd0, 5'd12), 5'd14);
		// Trailing NOPs keep fetch off unloaded words
		for (int i = 0; i < 4; i++)
			addRow(`MIPS_NOP, 5'd0);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic loadUseHazard(input logic [31:0] prev, input logic [31:0] cur);
		logic [4:0] dest;
		dest = prev[20:16];
		return (prev[31:26] == OpLw) && (dest != 5'd0) &&
			((dest == cur[25:21]) || (dest == cur[20:16]));
	endfunction

	task automatic modelStep(
		input logic [31:0] instr,
		output logic writes,
		output logic [31:0] value
	);
		logic [5:0] op;
		logic [4:0] dest;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immExt;
		logic [31:0] addr;
		int idx;
		logic lt;
		op = instr[31:26];
		a = modelRegs[instr[25:21]];
		b = modelRegs[instr[20:16]];
		immExt = {{16{instr[15]}}, instr[15:0]};
		addr = a + immExt;
		idx = (addr >> 2) % `MIPS_DMEM_DEPTH;
		lt = $signed(a) < $signed(b);
		writes = 1'b0;
		value = '0;
		dest = instr[20:16];
		if (op == OpAddiu)
		begin
			writes = 1'b1;
			value = addr;
		end
		else if (op == OpLw)
		begin
			writes = 1'b1;
			value = modelMem[idx];
		end
		else if (op == OpSw)
			modelMem[idx] = b;
		else if (op == OpSpecial)
		begin
			dest = instr[15:11];
			writes = 1'b1;
			case (instr[5:0])
				FnAddu: value = a + b;
				FnSubu: value = a - b;
				FnAnd: value = a & b;
				FnOr: value = a | b;
				FnSlt: value = {31'd0, lt};
				default: writes = 1'b0;
			endcase
		end
		// r0 stays zero
		if (writes && (dest != 5'd0))
			modelRegs[dest] = value;
	endtask

	// Retire cycle counts from the first edge out of reset
	task automatic buildExpectations();
		logic writes;
		logic [31:0] value;
		int stalls;
		stalls = 0;
		for (int r = 0; r < `MIPS_REGS; r++)
			modelRegs[r] = '0;
		for (int m = 0; m < `MIPS_DMEM_DEPTH; m++)
			modelMem[m] = '0;
		for (int i = 0; i < ProgLen; i++)
		begin
			if ((i > 0) && loadUseHazard(progInstr[i-1], progInstr[i]))
				stalls++;
			modelStep(progInstr[i], writes, value);
			if (writes)
			begin
				expCycle.push_back(RetireLatency + i + stalls);
				expReg.push_back(progDest[i]);
				expData.push_back(value);
			end
		end
	endtask

	// Watchdog
	initial
	begin
		#(RunCycles * ClkPeriod);
		$display("Watchdog expired: run went past %0d clock cycles", RunCycles);
		$display("Simulation failed");
		$fatal(1, "Timeout");
	end

	// Bound decode assertions stop the run at their first failure
	always @(u_MipsCore.u_InstructionDecode.u_asserts.failCount)
	begin
		if (u_MipsCore.u_InstructionDecode.u_asserts.failCount != 0)
		begin
			$display("A bound assertion on the decode stage failed");
			$display("Simulation failed");
			$fatal(1, "Assertion failure");
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int cycle;
		int nextRetire;
		int haltCycle;
		clk = 1'b0;
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		debugOn = 1'b0;
		debugReg = '0;
		seed = 32'hf1f7_a469;
		buildProgram();
		if (rowCount != ProgLen)
		begin
			$display("Program table has %0d rows instead of %0d", rowCount, ProgLen);
			$display("Simulation failed");
			$fatal(1, "Bad program table");
		end
		buildExpectations();

		// Program load while in reset
		for (int i = 0; i < ProgLen; i++)
		begin
			@(negedge clk);
			imemWe = 1'b1;
			imemAddr = i;
			imemData = progInstr[i];
		end
		@(negedge clk);
		imemWe = 1'b0;
		repeat (ResetCycles) @(negedge clk);
		rst = 1'b0;

		// One retire sample per cycle in program order
		cycle = 0;
		nextRetire = 0;
		// Halt lands while the last writer sits in ID/EX
		haltCycle = expCycle[expCycle.size() - 1] - 1;
		while (nextRetire < expCycle.size())
		begin
			@(negedge clk);
			cycle++;
			if (cycle == expCycle[nextRetire])
			begin
				checkValue("retireValid", 32'(retireValid), 32'd1);
				checkValue("retireReg", 32'(retireReg), 32'(expReg[nextRetire]));
				checkValue("retireData", retireData, expData[nextRetire]);
				nextRetire++;
			end
			else
				checkValue("retireValid", 32'(retireValid), 32'd0);
			// In flight writes still finish under the halt
			if (cycle == haltCycle)
				debugOn = 1'b1;
		end

		// Halted pipeline stays drained
		repeat (2)
		begin
			@(negedge clk);
			checkValue("retireValid", 32'(retireValid), 32'd0);
		end

		// Final register file through the debug port
		for (int r = 0; r < `MIPS_REGS; r++)
		begin
			@(negedge clk);
			debugReg = r[4:0];
			@(negedge clk);
			checkValue($sformatf("debugData r%0d", r), debugData, modelRegs[r]);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/mips_pkg.sv
fetch/InstructionFetch.sv
decode/HazardDetectionUnit.sv
decode/ControlBlock.sv
decode/FileRegister.sv
decode/InstructionDecode.sv
hdl/ExecuteStage.sv
hdl/MipsCore.sv
test/MipsCore_asserts.sv
test/MipsCore_tb.sv

/* Makefile */
# Verilator flow for the MIPS pipeline testbench

VERILATOR ?= verilator
FILELIST ?= sources.f
TOP ?= MipsCore_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG ?= Simulation failed
PASS_MSG ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
